// ==== nonogram_pkg.sv ====
package nonogram_pkg;

    // board limits
    localparam int MAX_DIM    = 8;
    localparam int NUM_LINES  = 2 * MAX_DIM;    // rows then columns
    localparam int LINE_IDX_W = 4;
    localparam int DIM_W      = 4;              // width of num_rows / num_cols

    // one line of cells with bit i as cell i along the line
    // a header word uses the same type with the line index in the low bits
    typedef logic [MAX_DIM-1:0] pattern_t;

    // rows come first and columns start at num_rows
    typedef logic [LINE_IDX_W-1:0] line_idx_t;

    // row-major with cell (r,c) at bit r*MAX_DIM+c
    typedef logic [MAX_DIM*MAX_DIM-1:0] board_t;

    typedef struct packed {
        pattern_t known;
        pattern_t assigned;
    } line_view_t;

    typedef struct packed {
        line_idx_t line;
        pattern_t  ones;    // one in every surviving pattern
        pattern_t  zeros;   // zero in every surviving pattern
    } line_update_t;

endpackage

// ==== board_state.sv ====
module board_state import nonogram_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  logic [DIM_W-1:0] num_rows,
    input  logic [DIM_W-1:0] num_cols,
    input  line_idx_t        view_line,
    input  line_update_t     upd,
    input  logic             upd_valid,
    output line_view_t       view,
    output board_t           known,
    output board_t           assigned,
    output logic             complete
);

    localparam int POS_W = $clog2(MAX_DIM);

    board_t act;        // cells inside num_rows x num_cols
    board_t set_ones;
    board_t set_zeros;

    // transposed copies indexed [col][row]
    logic [MAX_DIM-1:0][MAX_DIM-1:0] known_t;
    logic [MAX_DIM-1:0][MAX_DIM-1:0] assigned_t;

    logic             view_is_row;
    line_idx_t        view_col;
    logic [POS_W-1:0] view_pos;     // row number or column number

    logic             upd_is_row;
    line_idx_t        upd_col;
    logic [POS_W-1:0] upd_pos;

    // split a line index into row or column
    assign view_is_row = view_line < LINE_IDX_W'(num_rows);
    assign view_col    = view_line - LINE_IDX_W'(num_rows);
    assign view_pos    = view_is_row ? view_line[POS_W-1:0] : view_col[POS_W-1:0];

    assign upd_is_row  = upd.line < LINE_IDX_W'(num_rows);
    assign upd_col     = upd.line - LINE_IDX_W'(num_rows);
    assign upd_pos     = upd_is_row ? upd.line[POS_W-1:0] : upd_col[POS_W-1:0];

    for (genvar r = 0; r < MAX_DIM; r++) begin : g_row
        for (genvar c = 0; c < MAX_DIM; c++) begin : g_col
            assign known_t[c][r]      = known[r*MAX_DIM + c];
            assign assigned_t[c][r]   = assigned[r*MAX_DIM + c];
            assign act[r*MAX_DIM + c] = (r < num_rows) && (c < num_cols);
        end
    end

    // line view for the filter
    always_comb begin
        if (view_is_row) begin
            view.known    = known[view_pos*MAX_DIM +: MAX_DIM];
            view.assigned = assigned[view_pos*MAX_DIM +: MAX_DIM];
        end else begin
            view.known    = known_t[view_pos];
            view.assigned = assigned_t[view_pos];
        end
    end

    // spread the line update across the board
    always_comb begin
        set_ones  = '0;
        set_zeros = '0;
        for (int i = 0; i < MAX_DIM; i++) begin
            if (upd_is_row) begin
                set_ones[upd_pos*MAX_DIM + i]  = upd.ones[i];
                set_zeros[upd_pos*MAX_DIM + i] = upd.zeros[i];
            end else begin
                set_ones[i*MAX_DIM + upd_pos]  = upd.ones[i];
                set_zeros[i*MAX_DIM + upd_pos] = upd.zeros[i];
            end
        end
        // nothing lands outside the active region
        set_ones  = set_ones & act;
        set_zeros = set_zeros & act;
    end

    always_ff @(posedge clk) begin
        if (rst || start) begin
            known    <= '0;
            assigned <= '0;
        end else if (upd_valid) begin
            known    <= known | set_ones | set_zeros;
            assigned <= (assigned | set_ones) & ~set_zeros;
        end
    end

    // every active cell known while inactive cells count as done
    assign complete = &(known | ~act);

endmodule

// ==== option_filter.sv ====
module option_filter import nonogram_pkg::*; #(
    parameter int COUNT_W = 7
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              start,
    input  logic [NUM_LINES-1:0][COUNT_W-1:0] counts,
    input  pattern_t                          in_word,
    input  logic                              in_valid,
    output logic                              in_ready,
    output pattern_t                          out_word,
    output logic                              out_valid,
    input  logic                              out_ready,
    output line_idx_t                         view_line,
    input  line_view_t                        view,
    input  logic                              complete,
    output line_update_t                      upd,
    output logic                              upd_valid,
    output logic                              solved
);

    typedef enum logic [1:0] {
        IDLE,
        HEADER,
        FILTER,
        WRITE
    } state_t;

    state_t state;

    logic [NUM_LINES-1:0][COUNT_W-1:0] count_tab;  // options per line

    line_idx_t          cur_line;
    logic [COUNT_W-1:0] left;       // patterns still to read for this line
    logic [COUNT_W-1:0] kept;       // patterns passed back so far
    logic               single;     // line had exactly one option
    pattern_t           ones_acc;
    pattern_t           zeros_acc;

    line_idx_t          hdr_line;
    logic [COUNT_W-1:0] hdr_count;
    logic               out_free;
    logic               in_fire;
    logic               clash;
    logic               push;

    assign hdr_line  = in_word[LINE_IDX_W-1:0];
    assign hdr_count = count_tab[hdr_line];

    // output register is empty or drains this cycle
    assign out_free = !out_valid || out_ready;
    assign in_ready = out_free && (state == FILTER || (state == HEADER && !complete));
    assign in_fire  = in_valid && in_ready;

    // pattern disagrees with a known cell
    assign clash = |((in_word ^ view.assigned) & view.known);

    // header always goes back but a single option never does
    assign push = in_fire &&
                  (state == HEADER || (state == FILTER && !single && !clash));

    assign view_line = cur_line;
    assign upd_valid = (state == WRITE);

    // with no survivor both sets stay full and the masking leaves the line untouched
    assign upd = '{line:  cur_line,
                   ones:  ones_acc & ~zeros_acc,
                   zeros: zeros_acc & ~ones_acc};

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            out_valid <= 1'b0;
            solved    <= 1'b0;
        end else begin
            if (push) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end

            case (state)
                IDLE: begin
                    if (start) begin
                        state  <= HEADER;
                        solved <= 1'b0;
                    end
                end
                HEADER: begin
                    if (complete) begin
                        solved <= 1'b1;     // board done so stop reading
                        state  <= IDLE;
                    end else if (in_fire && hdr_count != '0) begin
                        state <= FILTER;
                    end
                end
                FILTER: begin
                    if (in_fire && left == COUNT_W'(1)) begin
                        state <= WRITE;
                    end
                end
                WRITE: state <= HEADER;     // board takes the update here
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            out_word <= in_word;
        end

        if (state == IDLE && start) begin
            count_tab <= counts;
        end
        if (state == WRITE) begin
            count_tab[cur_line] <= kept;
        end

        if (state == HEADER && in_fire) begin
            cur_line  <= hdr_line;
            left      <= hdr_count;
            single    <= (hdr_count == COUNT_W'(1));
            kept      <= '0;
            ones_acc  <= '1;
            zeros_acc <= '1;
        end

        if (state == FILTER && in_fire) begin
            left <= left - 1'b1;
            if (single || !clash) begin
                ones_acc  <= ones_acc & in_word;
                zeros_acc <= zeros_acc & ~in_word;
            end
            if (push) begin
                kept <= kept + 1'b1;
            end
        end
    end

endmodule

// ==== nonogram_solver.sv ====
module nonogram_solver import nonogram_pkg::*; #(
    parameter int COUNT_W = 7
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              start,
    input  logic [DIM_W-1:0]                  num_rows,
    input  logic [DIM_W-1:0]                  num_cols,
    input  logic [NUM_LINES-1:0][COUNT_W-1:0] counts,
    input  pattern_t                          in_word,
    input  logic                              in_valid,
    output logic                              in_ready,
    output pattern_t                          out_word,
    output logic                              out_valid,
    input  logic                              out_ready,
    output board_t                            known,
    output board_t                            assigned,
    output logic                              solved
);

    line_idx_t    view_line;
    line_view_t   view;
    line_update_t upd;
    logic         upd_valid;
    logic         complete;

    // the filter reads the queue and feeds the board
    option_filter #(
        .COUNT_W(COUNT_W)
    ) u_filter (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .counts    (counts),
        .in_word   (in_word),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_word  (out_word),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .view_line (view_line),
        .view      (view),
        .complete  (complete),
        .upd       (upd),
        .upd_valid (upd_valid),
        .solved    (solved)
    );

    board_state u_board (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .num_rows  (num_rows),
        .num_cols  (num_cols),
        .view_line (view_line),
        .upd       (upd),
        .upd_valid (upd_valid),
        .view      (view),
        .known     (known),
        .assigned  (assigned),
        .complete  (complete)
    );

endmodule

// ==== tb_puzzles.svh ====
localparam int PZ_ROWS  = 5;
localparam int PZ_COLS  = 6;
localparam int PZ_WORDS = 44;

// each record is a header word holding the line index followed by that line's options
// row options use bit c for column c and column options use bit r for row r
localparam pattern_t PZ_QUEUE [PZ_WORDS] = '{
    8'h00, 8'h3F,                                    // row 0 clue 6
    8'h01, 8'h0F, 8'h1E, 8'h3C,                      // row 1 clue 4
    8'h02, 8'h03, 8'h06, 8'h0C, 8'h18, 8'h30,        // row 2 clue 2
    8'h03, 8'h0F, 8'h1E, 8'h3C,                      // row 3 clue 4
    8'h04, 8'h1B, 8'h33, 8'h36,                      // row 4 clue 2 2
    8'h05, 8'h05, 8'h0A, 8'h09, 8'h12, 8'h11, 8'h14, // col 0 clue 1 1
    8'h06, 8'h1B,                                    // col 1 clue 2 2
    8'h07, 8'h0F, 8'h1E,                             // col 2 clue 4
    8'h08, 8'h0F, 8'h1E,                             // col 3 clue 4
    8'h09, 8'h1B,                                    // col 4 clue 2 2
    8'h0A, 8'h05, 8'h09, 8'h11, 8'h0A, 8'h12, 8'h14  // col 5 clue 1 1
};

// option count per line at start with unused lines at 0
localparam int PZ_COUNTS [NUM_LINES] = '{1, 3, 5, 3, 3, 6, 1, 2, 2, 1, 6, 0, 0, 0, 0, 0};

// solved rows with bit c as column c
localparam pattern_t PZ_SOLUTION [PZ_ROWS] = '{8'h3F, 8'h1E, 8'h0C, 8'h1E, 8'h33};

// ==== tb_nonogram_solver.sv ====
module tb_nonogram_solver import nonogram_pkg::*; ();

    localparam int COUNT_W = 7;
    localparam int TIMEOUT = 5000;  // cycles for the whole solve

    `include "tb_puzzles.svh"

    typedef enum int {T_RESET, T_STREAM, T_BOARD, T_QUEUE, T_SOLVE} test_t;

    logic clk = 1'b0;
    logic rst;
    logic start;
    logic [DIM_W-1:0] num_rows;
    logic [DIM_W-1:0] num_cols;
    logic [NUM_LINES-1:0][COUNT_W-1:0] counts;
    pattern_t in_word;
    logic in_valid;
    logic in_ready;
    pattern_t out_word;
    logic out_valid;
    logic out_ready;
    board_t known;
    board_t assigned;
    logic solved;

    pattern_t q [$];        // option queue feeding the DUT
    pattern_t mq [$];       // model queue including the word in the output register
    pattern_t exp_q [$];    // words still expected on out_word
    pattern_t m_known [MAX_DIM];
    pattern_t m_assigned [MAX_DIM];
    int m_count [NUM_LINES];
    line_idx_t m_line;
    int m_left;             // 0 means the next word is a header
    int m_kept;
    logic m_single;
    pattern_t m_ones;
    pattern_t m_zeros;
    int n_checks [5];
    int n_errors [5];
    string test_name [5] = '{"reset", "stream", "board", "queue", "solve"};
    logic [31:0] rng;

    nonogram_solver #(.COUNT_W(COUNT_W)) UUT (
        .clk(clk), .rst(rst), .start(start), .num_rows(num_rows), .num_cols(num_cols),
        .counts(counts), .in_word(in_word), .in_valid(in_valid), .in_ready(in_ready),
        .out_word(out_word), .out_valid(out_valid), .out_ready(out_ready),
        .known(known), .assigned(assigned), .solved(solved)
    );

    always #50 clk = ~clk;

    task automatic expect_equal(test_t t, string what, logic [63:0] exp, logic [63:0] act);
        n_checks[t]++;
        assert (act === exp) else begin
            $display("FAIL %s %s: expected %h, actual %h", test_name[t], what, exp, act);
            n_errors[t]++;
        end
    endtask

    task automatic require(test_t t, logic ok, string msg);
        n_checks[t]++;
        assert (ok) else begin
            $display("ERROR %s: %s", test_name[t], msg);
            n_errors[t]++;
        end
    endtask

    function automatic logic next_random();
        rng = rng * 32'd1103515245 + 32'd12345;
        return rng[16];
    endfunction

    function automatic line_view_t line_view_of(line_idx_t line);
        line_view_t v;
        int col;
        col = int'(line) - PZ_ROWS;
        for (int i = 0; i < MAX_DIM; i++) begin
            if (line < PZ_ROWS) begin
                v.known[i]    = m_known[line][i];
                v.assigned[i] = m_assigned[line][i];
            end else begin
                v.known[i]    = m_known[i][col];     // walk down the column
                v.assigned[i] = m_assigned[i][col];
            end
        end
        return v;
    endfunction

    task automatic write_line(line_idx_t line, pattern_t ones, pattern_t zeros);
        int len;
        int r;
        int c;
        len = (line < PZ_ROWS) ? PZ_COLS : PZ_ROWS;  // only cells on the active board
        for (int i = 0; i < len; i++) begin
            r = (line < PZ_ROWS) ? int'(line) : i;
            c = (line < PZ_ROWS) ? i : int'(line) - PZ_ROWS;
            if (ones[i] || zeros[i]) begin
                m_known[r][c]    = 1'b1;
                m_assigned[r][c] = ones[i];
            end
        end
    endtask

    task automatic take_word(pattern_t w);
        line_view_t v;
        logic clash;
        if (m_left == 0) begin
            m_line   = w[LINE_IDX_W-1:0];
            m_left   = m_count[m_line];
            m_single = (m_left == 1);
            m_kept   = 0;
            m_ones   = '1;
            m_zeros  = '1;
            exp_q.push_back(w);     // header always goes back
            mq.push_back(w);
        end else begin
            v = line_view_of(m_line);
            clash = 1'b0;
            for (int i = 0; i < MAX_DIM; i++) begin
                if (v.known[i] && w[i] != v.assigned[i]) begin
                    clash = 1'b1;   // a known cell disagrees
                end
            end
            if (m_single || !clash) begin
                m_ones  = m_ones & w;
                m_zeros = m_zeros & ~w;
            end
            if (!m_single && !clash) begin
                exp_q.push_back(w);
                mq.push_back(w);
                m_kept++;
            end
            m_left--;
            if (m_left == 0) begin  // end of record
                m_count[m_line] = m_kept;
                if (m_single || m_kept > 0) begin   // at least one pattern folded in
                    write_line(m_line, m_ones, m_zeros);
                end
            end
        end
    endtask

    function automatic board_t pack_board(logic want_known);
        board_t b;
        for (int r = 0; r < MAX_DIM; r++) begin
            b[r*MAX_DIM +: MAX_DIM] = want_known ? m_known[r] : m_assigned[r];
        end
        return b;
    endfunction

    function automatic board_t solution_board();
        board_t b;
        b = '0;
        for (int r = 0; r < PZ_ROWS; r++) begin
            b[r*MAX_DIM +: MAX_DIM] = PZ_SOLUTION[r];
        end
        return b;
    endfunction

    function automatic board_t active_mask();
        board_t b;
        b = '0;
        for (int r = 0; r < PZ_ROWS; r++) begin
            for (int c = 0; c < PZ_COLS; c++) begin
                b[r*MAX_DIM + c] = 1'b1;
            end
        end
        return b;
    endfunction

    task automatic compare_queue();
        pattern_t now [$];
        now = q;
        if (out_valid) begin
            now.push_back(out_word);    // still in the output register
        end
        expect_equal(T_QUEUE, "queue size", mq.size(), now.size());
        for (int i = 0; i < now.size() && i < mq.size(); i++) begin
            expect_equal(T_QUEUE, $sformatf("queue word %0d", i), mq[i], now[i]);
        end
    endtask

    task automatic print_result(test_t t);
        $display("%-6s %s (%0d checks, %0d errors)", test_name[t],
                 (n_errors[t] == 0) ? "ok" : "bad", n_checks[t], n_errors[t]);
    endtask

    initial begin
        logic done;
        logic in_fire;
        logic out_fire;
        int cycles;
        int total_checks;
        int total_errors;
        pattern_t w;
        rng = 32'd87883;
        rst = 1'b1;
        start = 1'b0;
        num_rows = DIM_W'(PZ_ROWS);
        num_cols = DIM_W'(PZ_COLS);
        in_word = '0;
        in_valid = 1'b0;
        out_ready = 1'b0;
        for (int i = 0; i < NUM_LINES; i++) begin
            counts[i] = COUNT_W'(PZ_COUNTS[i]);
            m_count[i] = PZ_COUNTS[i];
        end
        for (int i = 0; i < MAX_DIM; i++) begin
            m_known[i] = '0;
            m_assigned[i] = '0;
        end
        for (int i = 0; i < PZ_WORDS; i++) begin
            q.push_back(PZ_QUEUE[i]);
        end
        mq = q;
        m_left = 0;
        done = 1'b0;

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        expect_equal(T_RESET, "in_ready", 0, in_ready);
        expect_equal(T_RESET, "out_valid", 0, out_valid);
        expect_equal(T_RESET, "solved", 0, solved);
        expect_equal(T_RESET, "known", 0, known);
        expect_equal(T_RESET, "assigned", 0, assigned);
        print_result(T_RESET);

        @(posedge clk);
        start <= 1'b1;
        for (cycles = 0; cycles < TIMEOUT && !done; cycles++) begin
            @(negedge clk);
            in_fire  = in_valid && in_ready;
            out_fire = out_valid && out_ready;
            if (solved) begin
                done = 1'b1;
                compare_queue();
            end else begin
                // a new pass starts at the first header
                if (in_fire && m_left == 0 && q[0] == PZ_QUEUE[0]) begin
                    compare_queue();
                end
                if (out_fire) begin
                    require(T_STREAM, exp_q.size() > 0, "output word arrived with none expected");
                    if (exp_q.size() > 0) begin
                        expect_equal(T_STREAM, "out_word", exp_q.pop_front(), out_word);
                    end
                    q.push_back(out_word);  // loop back into the queue
                end
                if (in_fire) begin
                    w = q.pop_front();
                    void'(mq.pop_front());
                    if (m_left == 0) begin  // previous line's write has landed
                        expect_equal(T_BOARD, $sformatf("known at header %0d", w),
                                     pack_board(1), known);
                        expect_equal(T_BOARD, $sformatf("assigned at header %0d", w),
                                     pack_board(0), assigned);
                    end
                    take_word(w);
                end
                @(posedge clk);
                start     <= 1'b0;
                in_valid  <= (q.size() > 0);
                in_word   <= (q.size() > 0) ? q[0] : '0;
                out_ready <= next_random();
            end
        end

        if (!done) begin
            $display("timeout: solved still low after %0d cycles", TIMEOUT);
        end else begin
            expect_equal(T_SOLVE, "assigned", solution_board(), assigned);
            expect_equal(T_SOLVE, "known", active_mask(), known & active_mask());
            expect_equal(T_SOLVE, "known outside", 0, known & ~active_mask());
            expect_equal(T_BOARD, "final known", pack_board(1), known);
            expect_equal(T_BOARD, "final assigned", pack_board(0), assigned);
            require(T_STREAM, exp_q.size() == (out_valid ? 1 : 0), "words missing from output");
        end
        total_checks = 0;
        total_errors = 0;
        for (int t = 1; t < 5; t++) begin
            print_result(test_t'(t));
        end
        for (int t = 0; t < 5; t++) begin
            total_checks += n_checks[t];
            total_errors += n_errors[t];
        end
        $display("checks %0d, errors %0d", total_checks, total_errors);
        if (done && total_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== nonogram_solver.f ====
+incdir+.
nonogram_pkg.sv
board_state.sv
option_filter.sv
nonogram_solver.sv
tb_nonogram_solver.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_nonogram_solver -Mdir obj_dir \
    -f nonogram_solver.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_nonogram_solver > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASSED$" "$LOG"; then
    exit 0
fi
exit 1
